// File: keygen_pkg.sv
package keygen_pkg;

    // ======================================================================
    // Arithmetic constants
    // ======================================================================
    localparam int COEFF_W = 24;
    localparam int RAW_W   = 4;
    localparam int IDX_W   = 8;
    localparam int T1_W    = 10;
    localparam int T0_W    = 13;
    localparam int D_BITS  = 13;

    // Dilithium modulus
    localparam logic [COEFF_W-1:0] Q = 24'd8380417;

    // APB register offsets
    localparam logic [11:0] ADDR_LEVEL = 12'h000;
    localparam logic [11:0] ADDR_COUNT = 12'h004;

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic [2:0] sec_level_t;
    typedef logic [3:0] eta_t;

    // Payload between eta mapping and modular add
    typedef struct packed {
        logic [COEFF_W-1:0] a;
        logic [COEFF_W-1:0] s2;
        logic [IDX_W-1:0]   idx;
    } mapped_beat_t;

    // Payload between modular add and Power2Round
    typedef struct packed {
        logic [COEFF_W-1:0] t;
        logic [IDX_W-1:0]   idx;
    } t_beat_t;

    // Level 3 uses eta 4, everything else behaves as level 2 or 5
    function automatic eta_t eta_of_level(input sec_level_t level);
        case (level)
            3'd3:    return 4'd4;
            default: return 4'd2;
        endcase
    endfunction

endpackage

// File: keygen_apb_regs.sv
`timescale 1ns/1ps

module keygen_apb_regs #(
    parameter int APB_AW = 12
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [APB_AW-1:0]       i_paddr,
    input  logic [31:0]             i_pwdata,
    input  logic                    i_result_fire,
    output logic [31:0]             o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    output keygen_pkg::eta_t        o_eta
);

    keygen_pkg::sec_level_t level_q;
    logic [31:0]            count_q;
    logic                   setup_phase;
    logic                   access_phase;
    logic                   hit_level;
    logic                   hit_count;

    assign setup_phase  = i_psel && !i_penable;
    assign access_phase = i_psel && i_penable;
    assign hit_level    = (i_paddr == APB_AW'(keygen_pkg::ADDR_LEVEL));
    assign hit_count    = (i_paddr == APB_AW'(keygen_pkg::ADDR_COUNT));

    // No wait states
    assign o_pready = 1'b1;
    assign o_eta    = keygen_pkg::eta_of_level(level_q);

    // ======================================================================
    // Register storage
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= 3'd2;
            count_q <= '0;
        end else begin
            if (access_phase && i_pwrite && hit_level) begin
                level_q <= i_pwdata[2:0];
            end
            // Counter wraps naturally at 32 bits
            if (i_result_fire) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    // Response prepared in the setup cycle, presented in the access cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_prdata  <= '0;
            o_pslverr <= 1'b0;
        end else begin
            o_prdata  <= '0;
            o_pslverr <= setup_phase && !hit_level && !hit_count;
            if (setup_phase && !i_pwrite && hit_level) begin
                o_prdata <= {29'd0, level_q};
            end else if (setup_phase && !i_pwrite && hit_count) begin
                o_prdata <= count_q;
            end
        end
    end

    // Error response only ever lands on the access phase
    a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
        o_pslverr |-> access_phase);

endmodule

// File: coeff_skid.sv
`timescale 1ns/1ps

module coeff_skid #(
    parameter type PAYLOAD_T = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_valid,
    input  PAYLOAD_T i_data,
    output logic     o_ready,
    output logic     o_valid,
    output PAYLOAD_T o_data,
    input  logic     i_ready
);

    PAYLOAD_T   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    // Flags come straight from the occupancy register
    assign o_ready = (count_q != 2'd2);
    assign o_valid = (count_q != 2'd0);
    assign o_data  = mem[rd_ptr];

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    // ======================================================================
    // Pointers and occupancy
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count_q <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Stalled head must not change
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=> $stable(o_data));

endmodule

// File: eta_map_stage.sv
`timescale 1ns/1ps

module eta_map_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_valid,
    input  logic [keygen_pkg::COEFF_W-1:0]      i_a,
    input  logic [keygen_pkg::RAW_W-1:0]        i_s_raw,
    input  logic [keygen_pkg::IDX_W-1:0]        i_idx,
    input  keygen_pkg::eta_t                    i_eta,
    output logic                                o_ready,
    output logic                                o_valid,
    output keygen_pkg::mapped_beat_t            o_beat,
    input  logic                                i_ready
);

    localparam int CW = keygen_pkg::COEFF_W;

    logic          accept;
    logic [CW-1:0] eta_w;
    logic [CW-1:0] r_w;
    logic [CW-1:0] s2_mapped;

    // Register is free when empty or being drained
    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;

    assign eta_w = CW'(i_eta);
    assign r_w   = CW'(i_s_raw);

    // eta - r, wrapped into [0, q) when r exceeds eta
    always_comb begin
        if (r_w <= eta_w) begin
            s2_mapped = eta_w - r_w;
        end else begin
            s2_mapped = eta_w + keygen_pkg::Q - r_w;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_beat.a   <= i_a;
            o_beat.s2  <= s2_mapped;
            o_beat.idx <= i_idx;
        end
    end

    // Upstream contract on incoming samples
    a_raw_range: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ({1'b0, i_s_raw} <= {i_eta, 1'b0}));
    a_a_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (i_a < keygen_pkg::Q));

endmodule

// File: t_add_stage.sv
`timescale 1ns/1ps

module t_add_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_valid,
    input  keygen_pkg::mapped_beat_t    i_beat,
    output logic                        o_ready,
    output logic                        o_valid,
    output keygen_pkg::t_beat_t         o_beat,
    input  logic                        i_ready
);

    localparam int CW = keygen_pkg::COEFF_W;

    logic          accept;
    logic [CW:0]   sum;
    logic [CW:0]   sum_red;
    logic [CW-1:0] t_next;

    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;

    // Both operands below q, so one conditional subtract suffices
    assign sum     = {1'b0, i_beat.a} + {1'b0, i_beat.s2};
    assign sum_red = sum - {1'b0, keygen_pkg::Q};
    assign t_next  = (sum >= {1'b0, keygen_pkg::Q}) ? sum_red[CW-1:0] : sum[CW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_beat.t   <= t_next;
            o_beat.idx <= i_beat.idx;
        end
    end

    // Holds only if the eta stage delivered reduced operands
    a_t_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid |-> (o_beat.t < keygen_pkg::Q));

endmodule

// File: power2round_stage.sv
`timescale 1ns/1ps

module power2round_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_valid,
    input  keygen_pkg::t_beat_t                 i_beat,
    output logic                                o_ready,
    output logic                                o_valid,
    output logic [keygen_pkg::T1_W-1:0]         o_t1,
    output logic signed [keygen_pkg::T0_W-1:0]  o_t0,
    output logic [keygen_pkg::IDX_W-1:0]        o_idx,
    input  logic                                i_ready
);

    localparam int CW = keygen_pkg::COEFF_W;
    localparam int D  = keygen_pkg::D_BITS;

    logic                     accept;
    logic [CW:0]              t_round;
    logic [keygen_pkg::T1_W-1:0] t1_next;
    logic signed [CW+1:0]     t0_wide;

    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;

    // ======================================================================
    // Rounding
    // ======================================================================
    // t1 = (t + 2^(d-1) - 1) >> d, top bits are always zero for t < q
    assign t_round = {1'b0, i_beat.t} + (CW + 1)'(4095);
    assign t1_next = t_round[D +: keygen_pkg::T1_W];

    // Signed remainder t - t1 * 2^d
    assign t0_wide = $signed({2'b00, i_beat.t})
                   - $signed({3'b000, t1_next, {D{1'b0}}});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_t1  <= t1_next;
            o_t0  <= t0_wide[keygen_pkg::T0_W-1:0];
            o_idx <= i_beat.idx;
        end
    end

    // Centered remainder range for d = 13
    a_t0_range: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ((t0_wide >= -4095) && (t0_wide <= 4096)));

endmodule

// File: keygen_t_top.sv
`timescale 1ns/1ps

module keygen_t_top #(
    parameter int APB_AW = 12
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // APB configuration port
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [APB_AW-1:0]                   i_paddr,
    input  logic [31:0]                         i_pwdata,
    output logic [31:0]                         o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    // Coefficient input stream
    input  logic                                i_in_valid,
    input  logic [keygen_pkg::COEFF_W-1:0]      i_a,
    input  logic [keygen_pkg::RAW_W-1:0]        i_s_raw,
    input  logic [keygen_pkg::IDX_W-1:0]        i_idx,
    output logic                                o_in_ready,
    // Result stream
    output logic                                o_out_valid,
    output logic [keygen_pkg::T1_W-1:0]         o_t1,
    output logic signed [keygen_pkg::T0_W-1:0]  o_t0,
    output logic [keygen_pkg::IDX_W-1:0]        o_out_idx,
    input  logic                                i_out_ready
);

    keygen_pkg::eta_t         eta;
    keygen_pkg::mapped_beat_t map_beat;
    keygen_pkg::mapped_beat_t map_sk_beat;
    keygen_pkg::t_beat_t      t_beat;
    keygen_pkg::t_beat_t      t_sk_beat;
    logic                     map_valid;
    logic                     map_ready;
    logic                     map_sk_valid;
    logic                     map_sk_ready;
    logic                     t_valid;
    logic                     t_ready;
    logic                     t_sk_valid;
    logic                     t_sk_ready;
    wire                      result_fire = o_out_valid & i_out_ready;

    keygen_apb_regs #(.APB_AW(APB_AW)) apb_regs_i (
        .clk(clk), .rst_n(rst_n),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_result_fire(result_fire),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_eta(eta)
    );

    eta_map_stage eta_map_i (
        .clk(clk), .rst_n(rst_n),
        .i_valid(i_in_valid), .i_a(i_a), .i_s_raw(i_s_raw), .i_idx(i_idx),
        .i_eta(eta), .o_ready(o_in_ready),
        .o_valid(map_valid), .o_beat(map_beat), .i_ready(map_ready)
    );

    coeff_skid #(.PAYLOAD_T(keygen_pkg::mapped_beat_t)) map_skid_i (
        .clk(clk), .rst_n(rst_n),
        .i_valid(map_valid), .i_data(map_beat), .o_ready(map_ready),
        .o_valid(map_sk_valid), .o_data(map_sk_beat), .i_ready(map_sk_ready)
    );

    t_add_stage t_add_i (
        .clk(clk), .rst_n(rst_n),
        .i_valid(map_sk_valid), .i_beat(map_sk_beat), .o_ready(map_sk_ready),
        .o_valid(t_valid), .o_beat(t_beat), .i_ready(t_ready)
    );

    coeff_skid #(.PAYLOAD_T(keygen_pkg::t_beat_t)) t_skid_i (
        .clk(clk), .rst_n(rst_n),
        .i_valid(t_valid), .i_data(t_beat), .o_ready(t_ready),
        .o_valid(t_sk_valid), .o_data(t_sk_beat), .i_ready(t_sk_ready)
    );

    power2round_stage p2r_i (
        .clk(clk), .rst_n(rst_n),
        .i_valid(t_sk_valid), .i_beat(t_sk_beat), .o_ready(t_sk_ready),
        .o_valid(o_out_valid), .o_t1(o_t1), .o_t0(o_t0), .o_idx(o_out_idx),
        .i_ready(i_out_ready)
    );

endmodule

// File: tb_keygen_t_tasks.svh
`ifndef TB_KEYGEN_T_TASKS_SVH
`define TB_KEYGEN_T_TASKS_SVH

// ======================================================================
// APB and stream drivers
// ======================================================================
task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got == exp) else begin
        mismatch_errors++;
        $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

// Setup then access with the response sampled in the access phase
task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(negedge clk);
    i_penable = 1'b1;
    #1;
    assert (o_pready) else begin
        other_errors++;
        $display("APB slave held off the access phase at address %0h", addr);
    end
    rdata = o_prdata;
    err   = o_pslverr;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    if (wr && addr == LEVEL_ADDR) begin
        level_shadow = wdata[2:0];
    end
endtask

task automatic send_beat(input logic [23:0] a, input logic [3:0] r, input logic [7:0] idx);
    @(negedge clk);
    i_in_valid = 1'b1;
    i_a        = a;
    i_s_raw    = r;
    i_idx      = idx;
    #1;
    while (!o_in_ready) begin
        @(negedge clk);
        #1;
    end
    // Handshake lands on the next rising edge
    exp_q.push_back(model_beat(a, r, idx, expected_eta(level_shadow)));
    @(posedge clk);
endtask

task automatic idle_input(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        i_in_valid = 1'b0;
    end
endtask

task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
        @(negedge clk);
        cycles++;
    end
    assert (exp_q.size() == 0) else begin
        other_errors++;
        $display("Pipeline did not drain, %0d results never arrived", exp_q.size());
        exp_q.delete();
    end
endtask

// ======================================================================
// Directed tests
// ======================================================================
task automatic test_apb_regs();
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, LEVEL_ADDR, 32'd0, rd, err);
    compare_word(rd, 32'd2, "LEVEL after reset");
    apb_access(1'b1, LEVEL_ADDR, 32'd3, rd, err);
    apb_access(1'b0, LEVEL_ADDR, 32'd0, rd, err);
    compare_word(rd, 32'd3, "LEVEL after write of 3");
    apb_access(1'b0, BAD_ADDR, 32'd0, rd, err);
    compare_word({31'd0, err}, 32'd1, "PSLVERR on unmapped read");
    compare_word(rd, 32'd0, "read data on unmapped read");
    apb_access(1'b1, COUNT_ADDR, 32'h1234_5678, rd, err);
    compare_word({31'd0, err}, 32'd0, "PSLVERR on COUNT write");
    apb_access(1'b0, COUNT_ADDR, 32'd0, rd, err);
    compare_word(rd, 32'(seen_count), "COUNT after ignored write");
endtask

task automatic test_level2_stream();
    logic [31:0] rd;
    logic        err;
    int          i;
    apb_access(1'b1, LEVEL_ADDR, 32'd2, rd, err);
    for (i = 0; i < 256; i++) begin
        send_beat(24'(rand_bits(24) % 32'd8380417), 4'(rand_bits(3) % 32'd5), 8'(i));
    end
    idle_input(1);
    wait_drain();
endtask

task automatic test_level3_edges();
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, LEVEL_ADDR, 32'd3, rd, err);
    // Wrap from the top, wrap from below, then t at the rounding edges
    send_beat(24'd8380416, 4'd0, 8'd0);
    send_beat(24'd0, 4'd8, 8'd1);
    send_beat(24'd4095, 4'd4, 8'd2);
    send_beat(24'd4096, 4'd4, 8'd3);
    send_beat(24'd8191, 4'd4, 8'd4);
    idle_input(1);
    wait_drain();
endtask

task automatic test_backpressure();
    logic [31:0] rd;
    logic        err;
    int          k;
    int          j;
    apb_access(1'b1, LEVEL_ADDR, 32'd5, rd, err);
    for (k = 0; k < N_BP; k++) begin
        bp_a[k]   = 24'(rand_bits(24) % 32'd8380417);
        bp_r[k]   = 4'(rand_bits(3) % 32'd5);
        bp_gap[k] = 2'(rand_bits(2));
    end
    for (k = 0; k < RDY_LEN; k++) begin
        rdy_pat[k] = lfsr_bit();
    end
    bp_done = 1'b0;
    fork
        begin
            for (k = 0; k < N_BP; k++) begin
                if (bp_gap[k] != 2'd0) begin
                    idle_input(int'(bp_gap[k]));
                end
                send_beat(bp_a[k], bp_r[k], 8'(k));
            end
            idle_input(1);
            wait_drain();
            bp_done = 1'b1;
        end
        begin
            j = 0;
            while (!bp_done) begin
                @(negedge clk);
                i_out_ready = rdy_pat[j % RDY_LEN];
                j++;
            end
        end
    join
    @(negedge clk);
    i_out_ready = 1'b1;
endtask

task automatic test_result_count();
    logic [31:0] rd;
    logic        err;
    wait_drain();
    apb_access(1'b0, COUNT_ADDR, 32'd0, rd, err);
    compare_word(rd, 32'(seen_count), "COUNT against observed handshakes");
endtask

`endif

// File: tb_keygen_t.sv
`timescale 1ns/1ps

module tb_keygen_t;

    // ======================================================================
    // Timing constants, addresses and reference values
    // ======================================================================
    localparam int          CLK_PERIOD      = 4;
    localparam int          N_BP            = 200;
    localparam int          TOTAL_BEATS     = 256 + 5 + N_BP;
    localparam int          WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 1000;
    localparam int          DRAIN_LIMIT     = 200;
    localparam int          RDY_LEN         = 1024;
    localparam longint      Q_MOD           = 8380417;
    localparam logic [11:0] LEVEL_ADDR      = 12'h000;
    localparam logic [11:0] COUNT_ADDR      = 12'h004;
    localparam logic [11:0] BAD_ADDR        = 12'h008;

    logic               clk;
    logic               rst_n;
    logic               i_psel;
    logic               i_penable;
    logic               i_pwrite;
    logic [11:0]        i_paddr;
    logic [31:0]        i_pwdata;
    logic [31:0]        o_prdata;
    logic               o_pready;
    logic               o_pslverr;
    logic               i_in_valid;
    logic [23:0]        i_a;
    logic [3:0]         i_s_raw;
    logic [7:0]         i_idx;
    logic               o_in_ready;
    logic               o_out_valid;
    logic [9:0]         o_t1;
    logic signed [12:0] o_t0;
    logic [7:0]         o_out_idx;
    logic               i_out_ready;

    // Expected beats packed as {t1, t0, idx}
    logic [30:0] exp_q [$];
    logic [30:0] mon_exp;
    logic [30:0] mon_got;
    logic [2:0]  level_shadow;
    logic [15:0] lfsr_state = 16'd2731;
    int          seen_count;
    int          mismatch_errors;
    int          other_errors;
    logic        bp_done;
    logic [23:0] bp_a [N_BP];
    logic [3:0]  bp_r [N_BP];
    logic [1:0]  bp_gap [N_BP];
    logic        rdy_pat [RDY_LEN];

    keygen_t_top #(.APB_AW(12)) keygen_t_top_i (
        .clk(clk), .rst_n(rst_n),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .i_in_valid(i_in_valid), .i_a(i_a), .i_s_raw(i_s_raw), .i_idx(i_idx),
        .o_in_ready(o_in_ready),
        .o_out_valid(o_out_valid), .o_t1(o_t1), .o_t0(o_t0), .o_out_idx(o_out_idx),
        .i_out_ready(i_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int expected_eta(input logic [2:0] level);
        return (level == 3'd3) ? 4 : 2;
    endfunction

    // t = a + (eta - r) mod q followed by Power2Round with d = 13
    function automatic logic [30:0] model_beat(input logic [23:0] a, input logic [3:0] r,
                                               input logic [7:0] idx, input int eta);
        longint t;
        longint t1;
        longint t0;
        t  = (longint'(a) + longint'(eta) - longint'(r) + Q_MOD) % Q_MOD;
        t1 = (t + 4095) / 8192;
        t0 = t - t1 * 8192;
        return {t1[9:0], t0[12:0], idx};
    endfunction

    `include "tb_keygen_t_tasks.svh"

    // ======================================================================
    // Output monitor
    // ======================================================================
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (rst_n && o_out_valid && i_out_ready) begin
                seen_count++;
                mon_got = {o_t1, o_t0, o_out_idx};
                assert (exp_q.size() != 0) else begin
                    other_errors++;
                    $display("Output beat with index %0d arrived but none was pending",
                             o_out_idx);
                end
                if (exp_q.size() != 0) begin
                    mon_exp = exp_q.pop_front();
                    assert (mon_got == mon_exp) else begin
                        mismatch_errors++;
                        $display("MISMATCH at %0t: idx/t1/t0 %0d/%0d/%0d, expected %0d/%0d/%0d",
                                 $time, o_out_idx, o_t1, $signed(o_t0), mon_exp[7:0],
                                 mon_exp[30:21], $signed(mon_exp[20:8]));
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        i_psel          = 1'b0;
        i_penable       = 1'b0;
        i_pwrite        = 1'b0;
        i_paddr         = '0;
        i_pwdata        = '0;
        i_in_valid      = 1'b0;
        i_a             = '0;
        i_s_raw         = '0;
        i_idx           = '0;
        i_out_ready     = 1'b1;
        level_shadow    = 3'd2;
        seen_count      = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        bp_done         = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_apb_regs();
        test_level2_stream();
        test_level3_edges();
        test_backpressure();
        test_result_count();

        $display("Error summary: %0d mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
keygen_pkg.sv
keygen_apb_regs.sv
coeff_skid.sv
eta_map_stage.sv
t_add_stage.sv
power2round_stage.sv
keygen_t_top.sv
tb_keygen_t.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_keygen_t
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
